// ==== design/vdec_pkg.sv ====
package vdec_pkg;

  // machine sizes
  localparam int xlen = 32;
  localparam int vlen = 128;
  localparam int elen = 32;

  typedef logic [31:0] instr_t;

  // lsb of each instruction field
  localparam int opcode_lsb = 0;
  localparam int funct3_lsb = 12;
  localparam int rs1_lsb    = 15;
  localparam int zimm_lsb   = 20;
  localparam int funct6_lsb = 26;

  typedef logic [6:0] opcode_t;
  localparam opcode_t op_vector = 7'b1010111;

  // operand category, funct3 of the vector major opcode
  typedef enum logic [2:0] {
    opivv = 3'b000,
    opmvv = 3'b010,
    opivi = 3'b011,
    opivx = 3'b100,
    opmvx = 3'b110,
    opcfg = 3'b111
  } vfunct3_t;

  typedef logic [5:0] funct6_t;

  // integer OPI operations
  localparam funct6_t f6_vadd     = 6'b000000;
  localparam funct6_t f6_vsub     = 6'b000010;
  localparam funct6_t f6_vrsub    = 6'b000011;
  localparam funct6_t f6_vminu    = 6'b000100;
  localparam funct6_t f6_vmin     = 6'b000101;
  localparam funct6_t f6_vmaxu    = 6'b000110;
  localparam funct6_t f6_vmax     = 6'b000111;
  localparam funct6_t f6_vand     = 6'b001001;
  localparam funct6_t f6_vor      = 6'b001010;
  localparam funct6_t f6_vxor     = 6'b001011;
  localparam funct6_t f6_vmseq    = 6'b011000;
  localparam funct6_t f6_vmsne    = 6'b011001;
  localparam funct6_t f6_vmsltu   = 6'b011010;
  localparam funct6_t f6_vmslt    = 6'b011011;
  localparam funct6_t f6_vmsleu   = 6'b011100;
  localparam funct6_t f6_vmsle    = 6'b011101;
  localparam funct6_t f6_vmsgtu   = 6'b011110;
  localparam funct6_t f6_vmsgt    = 6'b011111;
  localparam funct6_t f6_vsll     = 6'b100101;
  localparam funct6_t f6_vsrl     = 6'b101000;
  localparam funct6_t f6_vsra     = 6'b101001;

  // OPM operations
  localparam funct6_t f6_vredsum  = 6'b000000;
  localparam funct6_t f6_vredand  = 6'b000001;
  localparam funct6_t f6_vredor   = 6'b000010;
  localparam funct6_t f6_vredxor  = 6'b000011;
  localparam funct6_t f6_vredminu = 6'b000100;
  localparam funct6_t f6_vredmin  = 6'b000101;
  localparam funct6_t f6_vredmaxu = 6'b000110;
  localparam funct6_t f6_vredmax  = 6'b000111;
  localparam funct6_t f6_vmandn   = 6'b011000;
  localparam funct6_t f6_vmand    = 6'b011001;
  localparam funct6_t f6_vmor     = 6'b011010;
  localparam funct6_t f6_vmxor    = 6'b011011;
  localparam funct6_t f6_vmorn    = 6'b011100;
  localparam funct6_t f6_vmnand   = 6'b011101;
  localparam funct6_t f6_vmnor    = 6'b011110;
  localparam funct6_t f6_vmxnor   = 6'b011111;
  localparam funct6_t f6_vdivu    = 6'b100000;
  localparam funct6_t f6_vdiv     = 6'b100001;
  localparam funct6_t f6_vremu    = 6'b100010;
  localparam funct6_t f6_vrem     = 6'b100011;
  localparam funct6_t f6_vmulhu   = 6'b100100;
  localparam funct6_t f6_vmul     = 6'b100101;
  localparam funct6_t f6_vmulhsu  = 6'b100110;
  localparam funct6_t f6_vmulh    = 6'b100111;
  localparam funct6_t f6_vwaddu   = 6'b110000;
  localparam funct6_t f6_vwadd    = 6'b110001;
  localparam funct6_t f6_vwsubu   = 6'b110010;
  localparam funct6_t f6_vwsub    = 6'b110011;
  localparam funct6_t f6_vwmulu   = 6'b111000;
  localparam funct6_t f6_vwmulsu  = 6'b111010;
  localparam funct6_t f6_vwmul    = 6'b111011;
  localparam funct6_t f6_vwmaccu  = 6'b111100;
  localparam funct6_t f6_vwmacc   = 6'b111101;
  localparam funct6_t f6_vwmaccus = 6'b111110;
  localparam funct6_t f6_vwmaccsu = 6'b111111;

  // element width codes, anything above sew_32 is unsupported
  typedef logic [2:0] vsew_t;
  localparam vsew_t sew_8  = 3'd0;
  localparam vsew_t sew_16 = 3'd1;
  localparam vsew_t sew_32 = 3'd2;

  typedef enum logic [7:0] {
    op_vadd, op_vsub, op_vrsub, op_vminu, op_vmin, op_vmaxu, op_vmax,
    op_vand, op_vor, op_vxor,
    op_vmseq, op_vmsne, op_vmsltu, op_vmslt, op_vmsleu, op_vmsle, op_vmsgtu, op_vmsgt,
    op_vsll, op_vsrl, op_vsra,
    op_vredsum, op_vredand, op_vredor, op_vredxor,
    op_vredminu, op_vredmin, op_vredmaxu, op_vredmax,
    op_vmandn, op_vmand, op_vmor, op_vmxor, op_vmorn, op_vmnand, op_vmnor, op_vmxnor,
    op_vdivu, op_vdiv, op_vremu, op_vrem,
    op_vmulhu, op_vmul, op_vmulhsu, op_vmulh,
    op_vwaddu, op_vwadd, op_vwsubu, op_vwsub,
    op_vwmulu, op_vwmulsu, op_vwmul,
    op_vwmaccu, op_vwmacc, op_vwmaccus, op_vwmaccsu,
    op_bad
  } vop_t;

  typedef enum logic [2:0] {fu_arith, fu_red, fu_mul, fu_div, fu_mask} fu_t;

  typedef enum logic [3:0] {
    valu_add, valu_sub, valu_and, valu_or, valu_xor,
    valu_sll, valu_srl, valu_sra, valu_comp, valu_minmax
  } valu_t;

  typedef enum logic [1:0] {not_cfg, vsetvli, vsetivli} cfg_t;

endpackage

// ==== design/vdec_opi_decode.sv ====
`timescale 1ns/1ps

module vdec_opi_decode import vdec_pkg::*; (
  input  funct6_t  funct6,
  input  vfunct3_t vfunct3,
  output vop_t     op
);

  logic vv;
  logic vx;
  logic vi;
  // operand form groups used by the table
  logic vv_vx;
  logic vx_vi;
  logic all_forms;

  assign vv = (vfunct3 == opivv);
  assign vx = (vfunct3 == opivx);
  assign vi = (vfunct3 == opivi);

  assign vv_vx     = vv || vx;
  assign vx_vi     = vx || vi;
  assign all_forms = vv || vx || vi;

  // an OPM or config funct3 matches no group and falls out as op_bad
  always_comb begin
    op = op_bad;
    case (funct6)
      f6_vadd:   op = all_forms ? op_vadd   : op_bad;
      f6_vsub:   op = vv_vx     ? op_vsub   : op_bad;
      f6_vrsub:  op = vx_vi     ? op_vrsub  : op_bad;

      // min/max have no immediate form
      f6_vminu:  op = vv_vx     ? op_vminu  : op_bad;
      f6_vmin:   op = vv_vx     ? op_vmin   : op_bad;
      f6_vmaxu:  op = vv_vx     ? op_vmaxu  : op_bad;
      f6_vmax:   op = vv_vx     ? op_vmax   : op_bad;

      f6_vand:   op = all_forms ? op_vand   : op_bad;
      f6_vor:    op = all_forms ? op_vor    : op_bad;
      f6_vxor:   op = all_forms ? op_vxor   : op_bad;

      // compares
      f6_vmseq:  op = all_forms ? op_vmseq  : op_bad;
      f6_vmsne:  op = all_forms ? op_vmsne  : op_bad;
      f6_vmsltu: op = vv_vx     ? op_vmsltu : op_bad;
      f6_vmslt:  op = vv_vx     ? op_vmslt  : op_bad;
      f6_vmsleu: op = all_forms ? op_vmsleu : op_bad;
      f6_vmsle:  op = all_forms ? op_vmsle  : op_bad;
      // greater-than only exists against a scalar or immediate
      f6_vmsgtu: op = vx_vi     ? op_vmsgtu : op_bad;
      f6_vmsgt:  op = vx_vi     ? op_vmsgt  : op_bad;

      // shifts
      f6_vsll:   op = all_forms ? op_vsll   : op_bad;
      f6_vsrl:   op = all_forms ? op_vsrl   : op_bad;
      f6_vsra:   op = all_forms ? op_vsra   : op_bad;
      default:   op = op_bad;
    endcase
  end

endmodule

// ==== design/vdec_opm_decode.sv ====
`timescale 1ns/1ps

module vdec_opm_decode import vdec_pkg::*; (
  input  funct6_t  funct6,
  input  vfunct3_t vfunct3,
  output vop_t     op
);

  logic mvv;
  logic mvx;
  logic mvv_mvx;

  assign mvv     = (vfunct3 == opmvv);
  assign mvx     = (vfunct3 == opmvx);
  assign mvv_mvx = mvv || mvx;

  always_comb begin
    op = op_bad;
    case (funct6)
      // reductions take vector operands only
      f6_vredsum:  op = mvv     ? op_vredsum  : op_bad;
      f6_vredand:  op = mvv     ? op_vredand  : op_bad;
      f6_vredor:   op = mvv     ? op_vredor   : op_bad;
      f6_vredxor:  op = mvv     ? op_vredxor  : op_bad;
      f6_vredminu: op = mvv     ? op_vredminu : op_bad;
      f6_vredmin:  op = mvv     ? op_vredmin  : op_bad;
      f6_vredmaxu: op = mvv     ? op_vredmaxu : op_bad;
      f6_vredmax:  op = mvv     ? op_vredmax  : op_bad;

      // mask-register logical, .mm form
      f6_vmandn:   op = mvv     ? op_vmandn   : op_bad;
      f6_vmand:    op = mvv     ? op_vmand    : op_bad;
      f6_vmor:     op = mvv     ? op_vmor     : op_bad;
      f6_vmxor:    op = mvv     ? op_vmxor    : op_bad;
      f6_vmorn:    op = mvv     ? op_vmorn    : op_bad;
      f6_vmnand:   op = mvv     ? op_vmnand   : op_bad;
      f6_vmnor:    op = mvv     ? op_vmnor    : op_bad;
      f6_vmxnor:   op = mvv     ? op_vmxnor   : op_bad;

      f6_vdivu:    op = mvv_mvx ? op_vdivu    : op_bad;
      f6_vdiv:     op = mvv_mvx ? op_vdiv     : op_bad;
      f6_vremu:    op = mvv_mvx ? op_vremu    : op_bad;
      f6_vrem:     op = mvv_mvx ? op_vrem     : op_bad;
      f6_vmulhu:   op = mvv_mvx ? op_vmulhu   : op_bad;
      f6_vmul:     op = mvv_mvx ? op_vmul     : op_bad;
      f6_vmulhsu:  op = mvv_mvx ? op_vmulhsu  : op_bad;
      f6_vmulh:    op = mvv_mvx ? op_vmulh    : op_bad;

      // widening, 2*SEW destination
      f6_vwaddu:   op = mvv_mvx ? op_vwaddu   : op_bad;
      f6_vwadd:    op = mvv_mvx ? op_vwadd    : op_bad;
      f6_vwsubu:   op = mvv_mvx ? op_vwsubu   : op_bad;
      f6_vwsub:    op = mvv_mvx ? op_vwsub    : op_bad;
      f6_vwmulu:   op = mvv_mvx ? op_vwmulu   : op_bad;
      f6_vwmulsu:  op = mvv_mvx ? op_vwmulsu  : op_bad;
      f6_vwmul:    op = mvv_mvx ? op_vwmul    : op_bad;
      f6_vwmaccu:  op = mvv_mvx ? op_vwmaccu  : op_bad;
      f6_vwmacc:   op = mvv_mvx ? op_vwmacc   : op_bad;
      // unsigned-by-signed macc has no vector-vector encoding
      f6_vwmaccus: op = mvx     ? op_vwmaccus : op_bad;
      f6_vwmaccsu: op = mvv_mvx ? op_vwmaccsu : op_bad;
      default:     op = op_bad;
    endcase
  end

endmodule

// ==== design/vdec_ctrl_gen.sv ====
`timescale 1ns/1ps

module vdec_ctrl_gen import vdec_pkg::*; (
  input  vop_t  op_opi,
  input  vop_t  op_opm,
  input  logic  is_opi,
  input  logic  is_opm,
  input  cfg_t  cfg,
  input  logic  vill,
  input  vsew_t vsew,
  output logic  illegal,
  output fu_t   fu,
  output valu_t alu_op,
  output logic  is_signed,
  output logic  vd_widen,
  output logic  mask_cmp
);

  vop_t op;
  logic is_cfg;

  // config and non-vector words select op_bad, so every control takes its default
  assign op     = is_opi ? op_opi : (is_opm ? op_opm : op_bad);
  assign is_cfg = (cfg != not_cfg);

  always_comb begin
    case (op)
      op_vredsum, op_vredand, op_vredor, op_vredxor,
      op_vredminu, op_vredmin, op_vredmaxu, op_vredmax: fu = fu_red;
      op_vmulhu, op_vmul, op_vmulhsu, op_vmulh, op_vwmulu, op_vwmulsu, op_vwmul,
      op_vwmaccu, op_vwmacc, op_vwmaccus, op_vwmaccsu: fu = fu_mul;
      op_vdivu, op_vdiv, op_vremu, op_vrem: fu = fu_div;
      op_vmandn, op_vmand, op_vmor, op_vmxor,
      op_vmorn, op_vmnand, op_vmnor, op_vmxnor: fu = fu_mask;
      default: fu = fu_arith;
    endcase
  end

  always_comb begin
    case (op)
      op_vsub, op_vrsub, op_vwsubu, op_vwsub: alu_op = valu_sub;
      op_vand, op_vredand, op_vmandn, op_vmand, op_vmnand: alu_op = valu_and;
      op_vor, op_vredor, op_vmor, op_vmorn, op_vmnor: alu_op = valu_or;
      op_vxor, op_vredxor, op_vmxor, op_vmxnor: alu_op = valu_xor;
      op_vsll: alu_op = valu_sll;
      op_vsrl: alu_op = valu_srl;
      op_vsra: alu_op = valu_sra;
      op_vmseq, op_vmsne, op_vmsltu, op_vmslt,
      op_vmsleu, op_vmsle, op_vmsgtu, op_vmsgt: alu_op = valu_comp;
      op_vminu, op_vmin, op_vmaxu, op_vmax,
      op_vredminu, op_vredmin, op_vredmaxu, op_vredmax: alu_op = valu_minmax;
      // adds, and the mul/div units which ignore it
      default: alu_op = valu_add;
    endcase
  end

  always_comb begin
    case (op)
      op_vadd, op_vsub, op_vrsub, op_vmin, op_vmax,
      op_vmseq, op_vmsne, op_vmslt, op_vmsle, op_vmsgt,
      op_vredsum, op_vredmin, op_vredmax, op_vdiv, op_vrem,
      op_vmul, op_vmulhsu, op_vmulh, op_vwadd, op_vwsub, op_vwmulsu, op_vwmul,
      op_vwmacc, op_vwmaccus, op_vwmaccsu: is_signed = 1'b1;
      default: is_signed = 1'b0;
    endcase
  end

  always_comb begin
    case (op)
      op_vwaddu, op_vwadd, op_vwsubu, op_vwsub, op_vwmulu, op_vwmulsu, op_vwmul,
      op_vwmaccu, op_vwmacc, op_vwmaccus, op_vwmaccsu: vd_widen = 1'b1;
      default: vd_widen = 1'b0;
    endcase
  end

  // compare results land in a mask register
  assign mask_cmp = (alu_op == valu_comp);

  // a widened result cannot exceed elen, so sew_32 leaves no room
  assign illegal = !is_cfg &&
                   ((op == op_bad) || vill || (vd_widen && (vsew == sew_32)));

endmodule

// ==== design/vdec_vtype_reg.sv ====
`timescale 1ns/1ps

module vdec_vtype_reg import vdec_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  logic            wr,
  input  cfg_t            cfg,
  input  logic [10:0]     zimm,
  input  logic [4:0]      uimm,
  input  logic [xlen-1:0] avl,
  output logic [xlen-1:0] vl,
  output vsew_t           vsew,
  output logic            vill
);

  vsew_t           new_sew;
  logic [2:0]      new_lmul;
  logic [xlen-1:0] app_len;
  logic [xlen-1:0] vlmax;
  logic            bad_vtype;

  // vtype layout: vlmul in [2:0], vsew in [5:3]
  assign new_lmul = zimm[2:0];
  assign new_sew  = zimm[5:3];

  // only LMUL=1 and element widths up to elen
  assign bad_vtype = (new_sew > sew_32) || (new_lmul != 3'b000);

  assign app_len = (cfg == vsetivli) ? xlen'(uimm) : avl;

  always_comb begin
    case (new_sew)
      sew_8:   vlmax = xlen'(vlen / 8);
      sew_16:  vlmax = xlen'(vlen / 16);
      default: vlmax = xlen'(vlen / elen);
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      vill <= 1'b1;
      vl   <= '0;
      vsew <= sew_8;
    end else if (wr) begin
      if (bad_vtype) begin
        vill <= 1'b1;
        vl   <= '0;
        vsew <= sew_8;
      end else begin
        vill <= 1'b0;
        vl   <= (app_len < vlmax) ? app_len : vlmax;
        vsew <= new_sew;
      end
    end
  end

endmodule

// ==== design/vdec_top.sv ====
`timescale 1ns/1ps

module vdec_top import vdec_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  logic            req,
  input  instr_t          instr,
  input  logic [xlen-1:0] avl,
  output logic            ack,
  output logic            illegal,
  output fu_t             fu,
  output valu_t           alu_op,
  output logic            is_signed,
  output logic            vd_widen,
  output logic            mask_cmp,
  output logic [xlen-1:0] vl,
  output vsew_t           vsew,
  output logic            vill
);

  typedef enum logic [1:0] {st_idle, st_decode, st_hold} state_t;

  state_t          state;
  instr_t          instr_q;
  logic [xlen-1:0] avl_q;

  opcode_t  opcode;
  vfunct3_t vfunct3;
  funct6_t  funct6;
  logic     is_vec;
  logic     is_opi;
  logic     is_opm;
  cfg_t     cfg;
  vop_t     op_opi;
  vop_t     op_opm;
  logic     vtype_wr;

  // decoded controls ahead of the output registers
  logic  illegal_d;
  fu_t   fu_d;
  valu_t alu_op_d;
  logic  is_signed_d;
  logic  vd_widen_d;
  logic  mask_cmp_d;

  // field split of the captured word
  assign opcode  = instr_q[opcode_lsb +: 7];
  assign vfunct3 = vfunct3_t'(instr_q[funct3_lsb +: 3]);
  assign funct6  = instr_q[funct6_lsb +: 6];

  assign is_vec = (opcode == op_vector);
  assign is_opi = is_vec && ((vfunct3 == opivv) || (vfunct3 == opivx) || (vfunct3 == opivi));
  assign is_opm = is_vec && ((vfunct3 == opmvv) || (vfunct3 == opmvx));

  // bit 31 clear is vsetvli, 11 is vsetivli, 10 (vsetvl) stays not_cfg
  always_comb begin
    cfg = not_cfg;
    if (is_vec && (vfunct3 == opcfg)) begin
      if (!instr_q[31]) begin
        cfg = vsetvli;
      end else if (instr_q[30]) begin
        cfg = vsetivli;
      end
    end
  end

  // vtype changes on the same edge that raises ack
  assign vtype_wr = (state == st_decode) && (cfg != not_cfg);

  vdec_opi_decode u_opi (
    .funct6  (funct6),
    .vfunct3 (vfunct3),
    .op      (op_opi)
  );

  vdec_opm_decode u_opm (
    .funct6  (funct6),
    .vfunct3 (vfunct3),
    .op      (op_opm)
  );

  vdec_ctrl_gen u_ctrl (
    .op_opi    (op_opi),
    .op_opm    (op_opm),
    .is_opi    (is_opi),
    .is_opm    (is_opm),
    .cfg       (cfg),
    .vill      (vill),
    .vsew      (vsew),
    .illegal   (illegal_d),
    .fu        (fu_d),
    .alu_op    (alu_op_d),
    .is_signed (is_signed_d),
    .vd_widen  (vd_widen_d),
    .mask_cmp  (mask_cmp_d)
  );

  vdec_vtype_reg u_vtype (
    .clk  (clk),
    .rst  (rst),
    .wr   (vtype_wr),
    .cfg  (cfg),
    .zimm (instr_q[zimm_lsb +: 11]),
    .uimm (instr_q[rs1_lsb +: 5]),
    .avl  (avl_q),
    .vl   (vl),
    .vsew (vsew),
    .vill (vill)
  );

  // four-phase handshake FSM
  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= st_idle;
      ack     <= 1'b0;
      illegal <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (req) begin
            state <= st_decode;
          end
        end
        st_decode: begin
          state   <= st_hold;
          ack     <= 1'b1;
          illegal <= illegal_d;
        end
        st_hold: begin
          // outputs hold for as long as req stays high
          if (!req) begin
            state <= st_idle;
            ack   <= 1'b0;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state == st_idle) && req) begin
      instr_q <= instr;
      avl_q   <= avl;
    end
  end

  always_ff @(posedge clk) begin
    if (state == st_decode) begin
      fu        <= fu_d;
      alu_op    <= alu_op_d;
      is_signed <= is_signed_d;
      vd_widen  <= vd_widen_d;
      mask_cmp  <= mask_cmp_d;
    end
  end

endmodule

// ==== tb/vdec_assert.sv ====
`timescale 1ns/1ps

module vdec_assert import vdec_pkg::*; (
  input logic            clk,
  input logic            rst,
  input logic            req,
  input logic            ack,
  input logic            illegal,
  input fu_t             fu,
  input valu_t           alu_op,
  input logic            is_signed,
  input logic            vd_widen,
  input logic            mask_cmp,
  input logic [xlen-1:0] vl,
  input vsew_t           vsew,
  input logic            vill
);

  // ack only answers a pending req
  assert property (@(posedge clk) disable iff (rst) $rose(ack) |-> $past(req))
    else $error("ack rose without req high");

  assert property (@(posedge clk) disable iff (rst) $fell(ack) |-> !$past(req))
    else $error("ack fell while req was still high");

  // everything the requester sees holds until req drops
  assert property (@(posedge clk) disable iff (rst) (ack && req) |=>
    $stable({illegal, fu, alu_op, is_signed, vd_widen, mask_cmp, vl, vsew, vill}))
    else $error("outputs changed while ack and req were high");

endmodule

bind vdec_top vdec_assert u_assert (.*);

// ==== tb/vdec_tb.sv ====
`timescale 1ns/1ps

module vdec_tb import vdec_pkg::*; ();

  localparam int max_cycles = 2000;
  localparam opcode_t op_alu = 7'b0110011;

  logic            clk;
  logic            rst;
  logic            req;
  instr_t          instr;
  logic [xlen-1:0] avl;
  logic            ack;
  logic            illegal;
  fu_t             fu;
  valu_t           alu_op;
  logic            is_signed;
  logic            vd_widen;
  logic            mask_cmp;
  logic [xlen-1:0] vl;
  vsew_t           vsew;
  logic            vill;

  // outputs as seen once ack is high
  logic  got_illegal;
  fu_t   got_fu;
  valu_t got_alu;
  logic  got_signed;
  logic  got_widen;
  logic  got_mask;

  int          errors;
  int          checks;
  int          cycles = 0;
  logic [31:0] rng;

  vdec_top uut (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .instr     (instr),
    .avl       (avl),
    .ack       (ack),
    .illegal   (illegal),
    .fu        (fu),
    .alu_op    (alu_op),
    .is_signed (is_signed),
    .vd_widen  (vd_widen),
    .mask_cmp  (mask_cmp),
    .vl        (vl),
    .vsew      (vsew),
    .vill      (vill)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("timeout: run went past %0d cycles", max_cycles);
      $display("tests failed");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // vm=1, vs2=2, vs1=1, vd=3
  function automatic instr_t vec_word(input funct6_t f6, input vfunct3_t f3);
    return {f6, 1'b1, 5'd2, 5'd1, f3, 5'd3, op_vector};
  endfunction

  function automatic instr_t setvli_word(input logic [2:0] sew, input logic [2:0] lmul);
    return {1'b0, 5'b0, sew, lmul, 5'd1, opcfg, 5'd1, op_vector};
  endfunction

  function automatic instr_t setivli_word(input logic [2:0] sew, input logic [4:0] uimm);
    return {2'b11, 4'b0, sew, 3'b000, uimm, opcfg, 5'd1, op_vector};
  endfunction

  // vl is the smaller of the requested length and vlen/SEW
  function automatic logic [31:0] expected_vl(input logic [31:0] app, input logic [2:0] sew);
    logic [31:0] vlmax;
    vlmax = 32'(vlen) >> (sew + 3'd3);
    return (app < vlmax) ? app : vlmax;
  endfunction

  task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  // one four-phase exchange with req kept high for hold extra cycles after ack
  task automatic issue_instr(input instr_t w, input logic [31:0] a, input int hold);
    int waited;
    int i;
    @(negedge clk);
    instr = w;
    avl   = a;
    req   = 1'b1;
    waited = 0;
    while (!ack && waited < 10) begin
      @(negedge clk);
      waited++;
    end
    if (!ack) begin
      errors++;
      $display("no ack within 10 cycles for instruction %h", w);
    end
    expect_eq("ack latency", waited, 2);
    got_illegal = illegal;
    got_fu      = fu;
    got_alu     = alu_op;
    got_signed  = is_signed;
    got_widen   = vd_widen;
    got_mask    = mask_cmp;
    for (i = 0; i < hold; i++) begin
      @(negedge clk);
      expect_eq("held ack", 32'(ack), 1);
      expect_eq("held illegal", 32'(illegal), 32'(got_illegal));
      expect_eq("held fu", 32'(fu), 32'(got_fu));
      expect_eq("held alu_op", 32'(alu_op), 32'(got_alu));
      expect_eq("held is_signed", 32'(is_signed), 32'(got_signed));
      expect_eq("held vd_widen", 32'(vd_widen), 32'(got_widen));
      expect_eq("held mask_cmp", 32'(mask_cmp), 32'(got_mask));
    end
    req = 1'b0;
    waited = 0;
    while (ack && waited < 10) begin
      @(negedge clk);
      waited++;
    end
    if (ack) begin
      errors++;
      $display("ack stayed high after req was released for %h", w);
    end
  endtask

  task automatic decode_check(input string name, input instr_t w, input logic e_ill,
                              input fu_t e_fu, input valu_t e_alu, input logic e_sgn,
                              input logic e_wd, input logic e_mc);
    issue_instr(w, 32'd0, 0);
    expect_eq({name, " illegal"}, 32'(got_illegal), 32'(e_ill));
    // remaining controls only matter for a legal word
    if (!e_ill) begin
      expect_eq({name, " fu"}, 32'(got_fu), 32'(e_fu));
      expect_eq({name, " alu_op"}, 32'(got_alu), 32'(e_alu));
      expect_eq({name, " is_signed"}, 32'(got_signed), 32'(e_sgn));
      expect_eq({name, " vd_widen"}, 32'(got_widen), 32'(e_wd));
      expect_eq({name, " mask_cmp"}, 32'(got_mask), 32'(e_mc));
    end
  endtask

  task automatic illegal_check(input string name, input instr_t w);
    decode_check(name, w, 1'b1, fu_arith, valu_add, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic set_vtype(input logic [2:0] sew, input logic [31:0] app);
    issue_instr(setvli_word(sew, 3'd0), app, 0);
    expect_eq("set_vtype vill", 32'(vill), 0);
    expect_eq("set_vtype vl", vl, expected_vl(app, sew));
  endtask

  task automatic reset_state();
    expect_eq("reset ack", 32'(ack), 0);
    expect_eq("reset illegal", 32'(illegal), 0);
    expect_eq("reset vill", 32'(vill), 1);
    expect_eq("reset vl", vl, 0);
    expect_eq("reset vsew", 32'(vsew), 0);
    illegal_check("vadd.vv under vill", vec_word(f6_vadd, opivv));
    illegal_check("vmul.vx under vill", vec_word(f6_vmul, opmvx));
  endtask

  task automatic vtype_config();
    logic [2:0]  sew;
    logic [31:0] app;
    logic [4:0]  uimm;
    int          i;
    for (i = 0; i < 20; i++) begin
      sew = 3'(i % 3);
      rng = xorshift(rng);
      // short lengths on even passes and the full range on odd ones
      app = (i % 2 == 0) ? rng % 40 : rng;
      issue_instr(setvli_word(sew, 3'd0), app, 0);
      expect_eq("vsetvli illegal", 32'(got_illegal), 0);
      expect_eq("vsetvli vill", 32'(vill), 0);
      expect_eq("vsetvli vsew", 32'(vsew), 32'(sew));
      expect_eq("vsetvli vl", vl, expected_vl(app, sew));
    end
    for (i = 0; i < 3; i++) begin
      sew = 3'(i);
      rng = xorshift(rng);
      uimm = rng[4:0];
      issue_instr(setivli_word(sew, uimm), 32'hffff_ffff, 0);
      expect_eq("vsetivli vsew", 32'(vsew), 32'(sew));
      expect_eq("vsetivli vl", vl, expected_vl(32'(uimm), sew));
    end
    issue_instr(setvli_word(3'd3, 3'd0), 32'd8, 0);
    expect_eq("sew 3 illegal", 32'(got_illegal), 0);
    expect_eq("sew 3 vill", 32'(vill), 1);
    expect_eq("sew 3 vl", vl, 0);
    expect_eq("sew 3 vsew", 32'(vsew), 0);
    set_vtype(3'd1, 32'd4);
    issue_instr(setvli_word(3'd0, 3'd1), 32'd8, 0);
    expect_eq("lmul 2 vill", 32'(vill), 1);
    expect_eq("lmul 2 vl", vl, 0);
    illegal_check("vadd.vv after bad vtype", vec_word(f6_vadd, opivv));
  endtask

  task automatic opi_decode_table();
    set_vtype(3'd0, 32'd16);
    decode_check("vadd.vi", vec_word(f6_vadd, opivi), 1'b0,
                 fu_arith, valu_add, 1'b1, 1'b0, 1'b0);
    decode_check("vsub.vv", vec_word(f6_vsub, opivv), 1'b0,
                 fu_arith, valu_sub, 1'b1, 1'b0, 1'b0);
    decode_check("vrsub.vi", vec_word(f6_vrsub, opivi), 1'b0,
                 fu_arith, valu_sub, 1'b1, 1'b0, 1'b0);
    decode_check("vminu.vx", vec_word(f6_vminu, opivx), 1'b0,
                 fu_arith, valu_minmax, 1'b0, 1'b0, 1'b0);
    decode_check("vand.vi", vec_word(f6_vand, opivi), 1'b0,
                 fu_arith, valu_and, 1'b0, 1'b0, 1'b0);
    decode_check("vor.vv", vec_word(f6_vor, opivv), 1'b0,
                 fu_arith, valu_or, 1'b0, 1'b0, 1'b0);
    decode_check("vxor.vx", vec_word(f6_vxor, opivx), 1'b0,
                 fu_arith, valu_xor, 1'b0, 1'b0, 1'b0);
    decode_check("vmseq.vi", vec_word(f6_vmseq, opivi), 1'b0,
                 fu_arith, valu_comp, 1'b1, 1'b0, 1'b1);
    decode_check("vmslt.vx", vec_word(f6_vmslt, opivx), 1'b0,
                 fu_arith, valu_comp, 1'b1, 1'b0, 1'b1);
    decode_check("vmsgtu.vi", vec_word(f6_vmsgtu, opivi), 1'b0,
                 fu_arith, valu_comp, 1'b0, 1'b0, 1'b1);
    decode_check("vsll.vi", vec_word(f6_vsll, opivi), 1'b0,
                 fu_arith, valu_sll, 1'b0, 1'b0, 1'b0);
    decode_check("vsrl.vx", vec_word(f6_vsrl, opivx), 1'b0,
                 fu_arith, valu_srl, 1'b0, 1'b0, 1'b0);
    decode_check("vsra.vv", vec_word(f6_vsra, opivv), 1'b0,
                 fu_arith, valu_sra, 1'b0, 1'b0, 1'b0);
    // combinations left out of the table
    illegal_check("vsub.vi", vec_word(f6_vsub, opivi));
    illegal_check("vrsub.vv", vec_word(f6_vrsub, opivv));
    illegal_check("vmax.vi", vec_word(f6_vmax, opivi));
    illegal_check("vmsltu.vi", vec_word(f6_vmsltu, opivi));
    illegal_check("vmsgt.vv", vec_word(f6_vmsgt, opivv));
    illegal_check("opi funct6 010000", vec_word(6'b010000, opivv));
  endtask

  task automatic opm_decode_table();
    decode_check("vredsum.vv", vec_word(f6_vredsum, opmvv), 1'b0,
                 fu_red, valu_add, 1'b1, 1'b0, 1'b0);
    decode_check("vmul.vx", vec_word(f6_vmul, opmvx), 1'b0,
                 fu_mul, valu_add, 1'b1, 1'b0, 1'b0);
    decode_check("vdivu.vv", vec_word(f6_vdivu, opmvv), 1'b0,
                 fu_div, valu_add, 1'b0, 1'b0, 1'b0);
    decode_check("vmand.mm", vec_word(f6_vmand, opmvv), 1'b0,
                 fu_mask, valu_and, 1'b0, 1'b0, 1'b0);
    illegal_check("vredsum.vx", vec_word(f6_vredsum, opmvx));
    illegal_check("vwmaccus.vv", vec_word(f6_vwmaccus, opmvv));
  endtask

  task automatic widening_rule();
    set_vtype(3'd0, 32'd10);
    decode_check("vwadd.vv sew8", vec_word(f6_vwadd, opmvv), 1'b0,
                 fu_arith, valu_add, 1'b1, 1'b1, 1'b0);
    set_vtype(3'd1, 32'd10);
    decode_check("vwadd.vv sew16", vec_word(f6_vwadd, opmvv), 1'b0,
                 fu_arith, valu_add, 1'b1, 1'b1, 1'b0);
    set_vtype(3'd2, 32'd10);
    illegal_check("vwadd.vv sew32", vec_word(f6_vwadd, opmvv));
    illegal_check("non-vector opcode", {f6_vadd, 1'b1, 5'd2, 5'd1, 3'b000, 5'd3, op_alu});
  endtask

  task automatic handshake_hold();
    int extra;
    set_vtype(3'd1, 32'd5);
    rng = xorshift(rng);
    extra = int'(rng % 5) + 1;
    issue_instr(vec_word(f6_vmslt, opivx), 32'd0, extra);
    expect_eq("held vmslt illegal", 32'(got_illegal), 0);
    expect_eq("held vmslt alu_op", 32'(got_alu), 32'(valu_comp));
    expect_eq("held vmslt mask_cmp", 32'(got_mask), 1);
    decode_check("vxor.vi after hold", vec_word(f6_vxor, opivi), 1'b0,
                 fu_arith, valu_xor, 1'b0, 1'b0, 1'b0);
  endtask

  initial begin
    rst    = 1'b1;
    req    = 1'b0;
    instr  = '0;
    avl    = '0;
    errors = 0;
    checks = 0;
    rng    = 32'h1835;
    repeat (4) @(negedge clk);
    rst = 1'b0;
    reset_state();
    vtype_config();
    opi_decode_table();
    opm_decode_table();
    widening_rule();
    handshake_hold();
    $display("checks: %0d errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== list.f ====
design/vdec_pkg.sv
design/vdec_opi_decode.sv
design/vdec_opm_decode.sv
design/vdec_ctrl_gen.sv
design/vdec_vtype_reg.sv
design/vdec_top.sv
tb/vdec_assert.sv
tb/vdec_tb.sv

// ==== Makefile ====
.PHONY: all run clean

all: run

obj_dir/Vvdec_tb: list.f $(wildcard design/*.sv) $(wildcard tb/*.sv)
	verilator --binary --timing --assert --top-module vdec_tb -f list.f -o Vvdec_tb

run: obj_dir/Vvdec_tb
	./obj_dir/Vvdec_tb | tee sim.log
	grep -q "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
